// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
TOP ?= tb_ps_header
FILELIST ?= project.f
LOG ?= sim.log
BIN = obj_dir/V$(TOP)
FAIL_MSG = >>> FAIL
PASS_MSG = >>> PASS

.PHONY: all run lint clean

all: run

$(BIN): $(FILELIST) $(wildcard verilog/*.sv tests/*.sv)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# a run that stops early prints neither message, so both are searched
run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG) || ! grep -qF '$(PASS_MSG)' $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)

// ==== project.f ====
verilog/ps_syntax_pkg.sv
verilog/ps_regs_pkg.sv
verilog/elastic_fifo.sv
verilog/start_code_detector.sv
verilog/system_header_parser.sv
verilog/stream_table_regs.sv
verilog/ps_header_top.sv
tests/ps_header_props.sv
tests/tb_ps_header.sv

// ==== tests/ps_header_props.sv ====
`timescale 1ns/1ns

module ps_header_props import ps_syntax_pkg::*; (
	input logic enable,
	input logic reset,
	input byte_beat_t in_beat,
	input logic in_valid,
	input logic in_ready,
	input sys_header_t hdr_out,
	input logic hdr_valid,
	input logic hdr_ready,
	input logic hdr_done,
	input logic [15:0] err_cnt
);
	int fail_count = 0; // read by the testbench at the end

	hdr_hold: assert property (@(posedge enable) disable iff (reset)
		hdr_valid && !hdr_ready |=> hdr_valid && $stable(hdr_out))
		else begin
			fail_count++;
			$error("hdr_out or hdr_valid changed while hdr_ready was low");
		end

	in_hold: assert property (@(posedge enable) disable iff (reset)
		in_valid && !in_ready |=> in_valid && $stable(in_beat))
		else begin
			fail_count++;
			$error("in_valid or in_beat changed while in_ready was low");
		end

	// output FIFO comes out of reset empty
	hdr_idle: assert property (@(posedge enable) reset |=> !hdr_valid)
		else begin
			fail_count++;
			$error("hdr_valid high right after reset");
		end

	no_err_on_done: assert property (@(posedge enable) disable iff (reset)
		hdr_done |=> err_cnt == $past(err_cnt))
		else begin
			fail_count++;
			$error("error counter rose together with a finished header");
		end

endmodule

bind ps_header_top ps_header_props props_i (
	.enable(enable), .reset(reset),
	.in_beat(in_beat), .in_valid(in_valid), .in_ready(in_ready),
	.hdr_out(hdr_out), .hdr_valid(hdr_valid), .hdr_ready(hdr_ready),
	.hdr_done(hdr_done), .err_cnt(regs_i.err_cnt_q)
);

// ==== tests/tb_ps_header.sv ====
`timescale 1ns/1ns

module tb_ps_header import ps_syntax_pkg::*, ps_regs_pkg::*; ();
	localparam int PERIOD = 20;
	localparam int AUDIO_SLOTS = 4;
	localparam int VIDEO_SLOTS = 4;
	localparam int SLOTS = AUDIO_SLOTS + VIDEO_SLOTS;
	localparam int STALL = 6; // worst case cycles per input byte

	logic enable;
	logic reset;
	byte_beat_t in_beat;
	logic in_valid;
	logic in_ready;
	sys_header_t hdr_out;
	logic hdr_valid;
	logic hdr_ready;
	reg_req_t reg_req;
	logic [15:0] reg_rdata;

	int seed = 32'h60f2;
	int errors = 0;
	bit model_en = 1'b1; // parse enable as the model sees it
	int exp_hdr = 0;
	int exp_err = 0;
	time deadline = 200 * PERIOD;
	logic [7:0] byte_q [$];
	logic [7:0] ids_q [$];
	sys_header_t exp_q [$];
	logic [15:0] exp_table [SLOTS];

	ps_header_top #(.AUDIO_SLOTS(AUDIO_SLOTS), .VIDEO_SLOTS(VIDEO_SLOTS), .FIFO_DEPTH(4)) dut_i (
		.enable(enable), .reset(reset),
		.in_beat(in_beat), .in_valid(in_valid), .in_ready(in_ready),
		.hdr_out(hdr_out), .hdr_valid(hdr_valid), .hdr_ready(hdr_ready),
		.reg_req(reg_req), .reg_rdata(reg_rdata)
	);

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			errors++;
			$display("MISMATCH at %0t ns: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
		end
	endtask

	// never zero, so payload cannot fake a prefix
	function automatic logic [7:0] rnd_byte();
		logic [31:0] r;
		r = $random(seed);
		return (r[7:0] == 8'h00) ? 8'h5A : r[7:0];
	endfunction

	function automatic int slot_of(input logic [7:0] id);
		int v;
		v = id;
		if (v >= 'hC0 && v < 'hC0 + AUDIO_SLOTS) begin
			return v - 'hC0;
		end
		if (v >= 'hE0 && v < 'hE0 + VIDEO_SLOTS) begin
			return AUDIO_SLOTS + v - 'hE0; // video slots follow audio
		end
		return -1;
	endfunction

	task automatic add_start(input logic [7:0] code);
		byte_q.push_back(8'h00);
		byte_q.push_back(8'h00);
		byte_q.push_back(8'h01);
		byte_q.push_back(code);
	endtask

	task automatic add_payload(input int n);
		repeat (n) begin
			byte_q.push_back(rnd_byte());
		end
	endtask

	// system header built from ids_q, expectations queued alongside
	task automatic add_header();
		logic [15:0] len;
		logic [23:0] rate;
		logic [15:0] flags;
		logic [7:0] rsv;
		logic [7:0] b1;
		logic [7:0] b2;
		bit bad;
		int slot;
		sys_header_t rec;
		len = 16'(6 + 3 * ids_q.size());
		rate = {rnd_byte(), rnd_byte(), rnd_byte()};
		flags = {rnd_byte(), rnd_byte()};
		rsv = rnd_byte();
		bad = 1'b0;
		add_start(SYS_HEADER_CODE);
		byte_q.push_back(len[15:8]); // big endian throughout
		byte_q.push_back(len[7:0]);
		byte_q.push_back(rate[23:16]);
		byte_q.push_back(rate[15:8]);
		byte_q.push_back(rate[7:0]);
		byte_q.push_back(flags[15:8]);
		byte_q.push_back(flags[7:0]);
		byte_q.push_back(rsv);
		foreach (ids_q[i]) begin
			b1 = 8'hC0 | (rnd_byte() & 8'h3F); // '11' then scale and size msbs
			b2 = rnd_byte();
			byte_q.push_back(ids_q[i]);
			byte_q.push_back(b1);
			byte_q.push_back(b2);
			bad = bad || !ids_q[i][7]; // header dropped from here on
			slot = slot_of(ids_q[i]);
			if (model_en && !bad && slot >= 0) begin
				exp_table[slot] = {1'b1, b1[5], 1'b0, b1[4:0], b2};
			end
		end
		rec.header_len = len;
		rec.rate_bound = rate;
		rec.flags = flags;
		rec.reserved = rsv;
		rec.entry_count = 8'(ids_q.size());
		if (model_en && bad) begin
			exp_err++;
		end else if (model_en) begin
			exp_q.push_back(rec);
			exp_hdr++;
		end
	endtask

	task automatic run_stream();
		deadline = $time + (byte_q.size() * STALL + 100) * PERIOD;
		while (byte_q.size() != 0) begin
			if (($random(seed) & 3) == 0) begin
				in_valid = 1'b0; // idle gap
				@(negedge enable);
			end
			in_valid = 1'b1;
			in_beat.data = byte_q.pop_front();
			while (!in_ready) @(negedge enable);
			@(negedge enable);
		end
		in_valid = 1'b0;
		while (exp_q.size() != 0 || dut_i.fifo_valid) @(negedge enable);
		@(negedge enable);
	endtask

	task automatic reg_read(input logic [7:0] addr, output logic [15:0] data);
		reg_req = '{valid: 1'b1, write: 1'b0, addr: addr, wdata: 16'h0000};
		@(negedge enable);
		reg_req = '0;
		data = reg_rdata;
	endtask

	task automatic reg_write(input logic [7:0] addr, input logic [15:0] val);
		reg_req = '{valid: 1'b1, write: 1'b1, addr: addr, wdata: val};
		@(negedge enable);
		reg_req = '0;
	endtask

	task automatic check_regs();
		logic [15:0] data;
		reg_read(REG_HDR_COUNT, data);
		check_val("REG_HDR_COUNT", data, exp_hdr);
		reg_read(REG_ERR_COUNT, data);
		check_val("REG_ERR_COUNT", data, exp_err);
		for (int k = 0; k < SLOTS; k++) begin
			reg_read(8'(REG_TABLE_BASE + k), data);
			check_val($sformatf("table slot %0d", k), data, exp_table[k]);
		end
	endtask

	task automatic check_record();
		sys_header_t exp;
		assert (exp_q.size() != 0) else begin
			errors++;
			$display("unexpected record on hdr_out at %0t ns, none was expected", $time);
		end
		if (exp_q.size() != 0) begin
			exp = exp_q.pop_front();
			check_val("hdr_out.header_len", hdr_out.header_len, exp.header_len);
			check_val("hdr_out.rate_bound", hdr_out.rate_bound, exp.rate_bound);
			check_val("hdr_out.flags", hdr_out.flags, exp.flags);
			check_val("hdr_out.reserved", hdr_out.reserved, exp.reserved);
			check_val("hdr_out.entry_count", hdr_out.entry_count, exp.entry_count);
		end
	endtask

	task automatic close_run(input bit timed_out);
		int prop_fails;
		prop_fails = dut_i.props_i.fail_count;
		$display("failed checks: %0d, failed properties: %0d, timeout: %0d",
			errors, prop_fails, timed_out);
		if (timed_out || errors != 0 || prop_fails != 0) begin
			$display(">>> FAIL");
		end else begin
			$display(">>> PASS");
		end
		$finish;
	endtask

	initial begin
		enable = 1'b0;
		forever #(PERIOD / 2) enable = ~enable;
	end

	// consumer, hdr_out is stable from one rising edge to the next
	initial begin
		hdr_ready = 1'b0;
		forever begin
			@(negedge enable);
			hdr_ready = $random(seed) & 1;
			if (hdr_valid && hdr_ready) begin
				check_record();
			end
		end
	end

	initial begin
		while ($time <= deadline) @(negedge enable);
		$display("timeout: run still busy at %0t ns, stream or records stuck", $time);
		close_run(1'b1);
	end

	initial begin
		reset = 1'b1;
		in_valid = 1'b0;
		in_beat = '0;
		reg_req = '0;
		foreach (exp_table[k]) begin
			exp_table[k] = 16'h0000;
		end
		repeat (4) @(negedge enable);
		reset = 1'b0;

		ids_q = {8'hC1, 8'hE2, 8'hC7}; // c7 lies past the audio slots
		add_header();
		run_stream();
		check_regs();

		add_start(8'hBA); // pack header, then pes with zero runs
		add_payload(8);
		add_start(8'hE0);
		add_payload(3);
		byte_q.push_back(8'h00);
		byte_q.push_back(8'h00);
		byte_q.push_back(8'h05);
		add_payload(4);
		ids_q = {8'hC0, 8'hE0, 8'hB9};
		add_header();
		run_stream();
		check_regs();

		ids_q = {8'h45, 8'hC2, 8'hE1}; // bit 7 clear on the first id
		add_header();
		ids_q = {8'hC2, 8'hE1, 8'hE3};
		add_header();
		run_stream();
		check_regs();

		ids_q = {8'hC3, 8'hE0};
		add_header();
		ids_q = {};
		add_header();
		ids_q = {8'hC0, 8'hC1, 8'hE2};
		add_header();
		ids_q = {8'hE3};
		add_header();
		run_stream();
		check_regs();

		reg_write(REG_CTRL, 16'h0000);
		model_en = 1'b0;
		ids_q = {8'hC0, 8'hE1};
		add_header();
		run_stream();
		check_regs();
		begin : ctrl_read
			logic [15:0] ctrl;
			reg_read(REG_CTRL, ctrl);
			check_val("REG_CTRL", ctrl, 32'h0);
		end
		reg_write(REG_CTRL, 16'h0001);
		model_en = 1'b1;
		ids_q = {8'hC1};
		add_header();
		run_stream();
		check_regs();
		close_run(1'b0);
	end

endmodule

// ==== verilog/elastic_fifo.sv ====
`timescale 1ns/1ns

module elastic_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int FIFO_DEPTH = 4,
	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1,
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1)
) (
	input logic enable,
	input logic reset,
	input payload_t s_data,
	input logic s_valid,
	output logic s_ready,
	output payload_t m_data,
	output logic m_valid,
	input logic m_ready
);
	payload_t mem [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr_q;
	logic [PTR_W-1:0] rd_ptr_q;
	logic [CNT_W-1:0] count_q;
	logic live_q; // ready stays low for one cycle out of reset
	logic push;
	logic pop;

	assign s_ready = live_q && (count_q != CNT_W'(FIFO_DEPTH));
	assign m_valid = (count_q != '0);
	assign m_data = mem[rd_ptr_q];
	assign push = s_valid && s_ready;
	assign pop = m_valid && m_ready;

	always_ff @(posedge enable) begin
		if (push) begin
			mem[wr_ptr_q] <= s_data;
		end
	end

	always_ff @(posedge enable) begin
		if (reset) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q <= '0;
			live_q <= 1'b0;
		end else begin
			live_q <= 1'b1;
			if (push) begin
				wr_ptr_q <= (wr_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
			end
			if (pop) begin
				rd_ptr_q <= (rd_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
			end
			count_q <= count_q + CNT_W'(push) - CNT_W'(pop); // both at once keeps level
		end
	end

endmodule

// ==== verilog/ps_header_top.sv ====
`timescale 1ns/1ns

module ps_header_top import ps_syntax_pkg::*, ps_regs_pkg::*; #(
	parameter int AUDIO_SLOTS = 4,
	parameter int VIDEO_SLOTS = 4,
	parameter int FIFO_DEPTH = 4,
	localparam int SLOTS = AUDIO_SLOTS + VIDEO_SLOTS,
	localparam int SLOT_W = (SLOTS > 1) ? $clog2(SLOTS) : 1
) (
	input logic enable,
	input logic reset,
	input byte_beat_t in_beat,
	input logic in_valid,
	output logic in_ready,
	output sys_header_t hdr_out,
	output logic hdr_valid,
	input logic hdr_ready,
	input reg_req_t reg_req,
	output logic [15:0] reg_rdata
);
	byte_beat_t fifo_beat;
	logic fifo_valid;
	logic fifo_ready;
	tagged_beat_t tag_beat;
	logic tag_valid;
	logic tag_ready;
	sys_header_t rec;
	logic rec_valid;
	logic rec_ready;
	logic parse_enable;
	logic entry_we;
	logic [SLOT_W-1:0] entry_slot;
	pstd_entry_t entry;
	logic hdr_done;
	logic err;

	elastic_fifo #(.payload_t(byte_beat_t), .FIFO_DEPTH(FIFO_DEPTH)) in_fifo (
		.enable(enable), .reset(reset),
		.s_data(in_beat), .s_valid(in_valid), .s_ready(in_ready),
		.m_data(fifo_beat), .m_valid(fifo_valid), .m_ready(fifo_ready)
	);

	start_code_detector detector_i (
		.enable(enable), .reset(reset),
		.s_beat(fifo_beat), .s_valid(fifo_valid), .s_ready(fifo_ready),
		.m_beat(tag_beat), .m_valid(tag_valid), .m_ready(tag_ready)
	);

	system_header_parser #(.AUDIO_SLOTS(AUDIO_SLOTS), .VIDEO_SLOTS(VIDEO_SLOTS)) parser_i (
		.enable(enable), .reset(reset),
		.s_beat(tag_beat), .s_valid(tag_valid), .s_ready(tag_ready),
		.parse_enable(parse_enable),
		.m_hdr(rec), .m_valid(rec_valid), .m_ready(rec_ready),
		.entry_we(entry_we), .entry_slot(entry_slot), .entry(entry),
		.hdr_done(hdr_done), .err(err)
	);

	elastic_fifo #(.payload_t(sys_header_t), .FIFO_DEPTH(FIFO_DEPTH)) hdr_fifo (
		.enable(enable), .reset(reset),
		.s_data(rec), .s_valid(rec_valid), .s_ready(rec_ready),
		.m_data(hdr_out), .m_valid(hdr_valid), .m_ready(hdr_ready)
	);

	stream_table_regs #(.AUDIO_SLOTS(AUDIO_SLOTS), .VIDEO_SLOTS(VIDEO_SLOTS)) regs_i (
		.enable(enable), .reset(reset),
		.reg_req(reg_req), .reg_rdata(reg_rdata),
		.parse_enable(parse_enable),
		.entry_we(entry_we), .entry_slot(entry_slot), .entry(entry),
		.hdr_done(hdr_done), .err(err)
	);

endmodule

// ==== verilog/ps_regs_pkg.sv ====
package ps_regs_pkg;

	localparam logic [7:0] REG_CTRL = 8'h00; // bit 0 parse enable
	localparam logic [7:0] REG_HDR_COUNT = 8'h01; // read only
	localparam logic [7:0] REG_ERR_COUNT = 8'h02; // read only
	localparam logic [7:0] REG_TABLE_BASE = 8'h10; // audio slots, then video

	// register port request, read data comes back a cycle later
	typedef struct packed {
		logic valid;
		logic write;
		logic [7:0] addr;
		logic [15:0] wdata;
	} reg_req_t;

endpackage

// ==== verilog/ps_syntax_pkg.sv ====
package ps_syntax_pkg;

	localparam logic [7:0] SYS_HEADER_CODE = 8'hBB; // system header stream id
	localparam logic [7:0] AUDIO_ID_BASE = 8'hC0; // first mpeg audio stream id
	localparam logic [7:0] VIDEO_ID_BASE = 8'hE0; // first mpeg video stream id
	localparam logic [15:0] FIXED_FIELD_BYTES = 16'd6; // rate, flags and reserved

	// raw byte as it arrives on the input port
	typedef struct packed {
		logic [7:0] data;
	} byte_beat_t;

	// byte after start code detection
	typedef struct packed {
		logic [7:0] data;
		logic is_code; // stream id right after 00 00 01
		logic in_unit; // belongs to the unit after the last code
	} tagged_beat_t;

	// one parsed system header
	typedef struct packed {
		logic [15:0] header_len;
		logic [23:0] rate_bound; // raw, marker bits kept
		logic [15:0] flags;
		logic [7:0] reserved;
		logic [7:0] entry_count; // p-std entries seen
	} sys_header_t;

	// one stream table slot
	typedef struct packed {
		logic present;
		logic buf_scale;
		logic [12:0] buf_size;
	} pstd_entry_t;

endpackage

// ==== verilog/start_code_detector.sv ====
`timescale 1ns/1ns

module start_code_detector import ps_syntax_pkg::*; (
	input logic enable,
	input logic reset,
	input byte_beat_t s_beat,
	input logic s_valid,
	output logic s_ready,
	output tagged_beat_t m_beat,
	output logic m_valid,
	input logic m_ready
);
	logic [1:0] zero_cnt_q; // saturates at two
	logic armed_q; // prefix seen, next byte is the stream id
	logic unit_q; // inside the unit after a code
	logic xfer;
	logic prefix_end;

	assign xfer = s_valid && m_ready;

	// 01 byte that completes a 00 00 01 prefix
	assign prefix_end = !armed_q && (zero_cnt_q == 2'd2) && (s_beat.data == 8'h01);

	// no storage on the data path
	assign s_ready = m_ready;
	assign m_valid = s_valid;
	assign m_beat.data = s_beat.data;
	assign m_beat.is_code = armed_q;
	assign m_beat.in_unit = unit_q && !prefix_end; // 01 marks end of previous unit

	always_ff @(posedge enable) begin
		if (reset) begin
			zero_cnt_q <= 2'd0;
			armed_q <= 1'b0;
			unit_q <= 1'b0;
		end else if (xfer) begin
			if (armed_q) begin
				armed_q <= 1'b0;
				unit_q <= 1'b1;
				zero_cnt_q <= (s_beat.data == 8'h00) ? 2'd1 : 2'd0; // id 00 may start a prefix
			end else if (prefix_end) begin
				armed_q <= 1'b1;
				unit_q <= 1'b0;
				zero_cnt_q <= 2'd0;
			end else if (s_beat.data == 8'h00) begin
				if (zero_cnt_q != 2'd2) begin
					zero_cnt_q <= zero_cnt_q + 2'd1;
				end
			end else begin
				zero_cnt_q <= 2'd0;
			end
		end
	end

endmodule

// ==== verilog/stream_table_regs.sv ====
`timescale 1ns/1ns

module stream_table_regs import ps_syntax_pkg::*, ps_regs_pkg::*; #(
	parameter int AUDIO_SLOTS = 4,
	parameter int VIDEO_SLOTS = 4,
	localparam int SLOTS = AUDIO_SLOTS + VIDEO_SLOTS,
	localparam int SLOT_W = (SLOTS > 1) ? $clog2(SLOTS) : 1
) (
	input logic enable,
	input logic reset,
	input reg_req_t reg_req,
	output logic [15:0] reg_rdata,
	output logic parse_enable,
	input logic entry_we,
	input logic [SLOT_W-1:0] entry_slot,
	input pstd_entry_t entry,
	input logic hdr_done,
	input logic err
);
	pstd_entry_t table_q [SLOTS];
	logic ctrl_q;
	logic [15:0] hdr_cnt_q;
	logic [15:0] err_cnt_q;
	logic [7:0] tbl_off;
	logic tbl_hit;
	pstd_entry_t sel_entry;
	logic [15:0] rd_val;

	assign parse_enable = ctrl_q;
	assign tbl_off = reg_req.addr - REG_TABLE_BASE;
	assign tbl_hit = (reg_req.addr >= REG_TABLE_BASE) && (tbl_off < SLOTS);
	assign sel_entry = table_q[SLOT_W'(tbl_off)];

	always_comb begin
		case (reg_req.addr)
			REG_CTRL: rd_val = {15'd0, ctrl_q};
			REG_HDR_COUNT: rd_val = hdr_cnt_q;
			REG_ERR_COUNT: rd_val = err_cnt_q;
			// slot layout: present 15, scale 14, size 12:0
			default: rd_val = tbl_hit ?
				{sel_entry.present, sel_entry.buf_scale, 1'b0, sel_entry.buf_size} : 16'h0000;
		endcase
	end

	always_ff @(posedge enable) begin
		if (reset) begin
			ctrl_q <= 1'b1; // parsing on out of reset
			hdr_cnt_q <= 16'd0;
			err_cnt_q <= 16'd0;
			reg_rdata <= 16'd0;
			for (int i = 0; i < SLOTS; i++) begin
				table_q[i] <= '0;
			end
		end else begin
			if (reg_req.valid && !reg_req.write) begin
				reg_rdata <= rd_val;
			end
			if (reg_req.valid && reg_req.write && (reg_req.addr == REG_CTRL)) begin
				ctrl_q <= reg_req.wdata[0];
			end
			if (entry_we) begin
				table_q[entry_slot] <= entry;
			end
			if (hdr_done) begin
				hdr_cnt_q <= hdr_cnt_q + 16'd1; // wraps
			end
			if (err) begin
				err_cnt_q <= err_cnt_q + 16'd1;
			end
		end
	end

endmodule

// ==== verilog/system_header_parser.sv ====
`timescale 1ns/1ns

module system_header_parser import ps_syntax_pkg::*; #(
	parameter int AUDIO_SLOTS = 4,
	parameter int VIDEO_SLOTS = 4,
	localparam int SLOTS = AUDIO_SLOTS + VIDEO_SLOTS,
	localparam int SLOT_W = (SLOTS > 1) ? $clog2(SLOTS) : 1
) (
	input logic enable,
	input logic reset,
	input tagged_beat_t s_beat,
	input logic s_valid,
	output logic s_ready,
	input logic parse_enable,
	output sys_header_t m_hdr,
	output logic m_valid,
	input logic m_ready,
	output logic entry_we,
	output logic [SLOT_W-1:0] entry_slot,
	output pstd_entry_t entry,
	output logic hdr_done,
	output logic err
);
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_FIXED,
		ST_ENTRY
	} state_t;

	state_t state_q;
	logic [2:0] idx_q; // byte within the fixed fields
	logic [1:0] grp_q; // byte within a p-std entry
	logic [15:0] remain_q; // entry bytes still to come
	logic slot_hit_q; // current id maps to a table slot
	logic [SLOT_W-1:0] slot_q;
	logic [7:0] b1_q; // scale and size msbs of current entry
	sys_header_t hdr_q;
	logic [15:0] len;
	logic len_bad;
	logic at_last;
	logic bad_byte;
	logic push_ok;
	logic xfer;
	logic id_audio;
	logic id_video;
	logic [SLOT_W-1:0] id_slot;

	assign len = {hdr_q.header_len[15:8], s_beat.data};
	assign len_bad = (len < FIXED_FIELD_BYTES) || ((len - FIXED_FIELD_BYTES) % 16'd3 != 16'd0);
	assign at_last = ((state_q == ST_FIXED) && (idx_q == 3'd7) && (remain_q == 16'd0)) ||
		((state_q == ST_ENTRY) && (remain_q == 16'd1));
	assign bad_byte = !s_beat.in_unit || // new start code inside the header
		((state_q == ST_FIXED) && (idx_q == 3'd1) && len_bad) ||
		((state_q == ST_ENTRY) && (grp_q == 2'd0) && !s_beat.data[7]);
	assign push_ok = at_last && !bad_byte;

	assign s_ready = push_ok ? m_ready : 1'b1; // stall only on the closing byte
	assign xfer = s_valid && s_ready;
	assign m_valid = s_valid && push_ok;
	assign hdr_done = m_valid && m_ready;
	assign err = xfer && (state_q != ST_IDLE) && bad_byte;

	assign id_audio = (s_beat.data >= AUDIO_ID_BASE) && (s_beat.data < AUDIO_ID_BASE + AUDIO_SLOTS);
	assign id_video = (s_beat.data >= VIDEO_ID_BASE) && (s_beat.data < VIDEO_ID_BASE + VIDEO_SLOTS);
	assign id_slot = id_audio ? SLOT_W'(s_beat.data - AUDIO_ID_BASE) :
		SLOT_W'(AUDIO_SLOTS + (s_beat.data - VIDEO_ID_BASE));

	assign entry_we = xfer && (state_q == ST_ENTRY) && (grp_q == 2'd2) && !bad_byte && slot_hit_q;
	assign entry_slot = slot_q;
	assign entry.present = 1'b1;
	assign entry.buf_scale = b1_q[5];
	assign entry.buf_size = {b1_q[4:0], s_beat.data};

	always_comb begin
		m_hdr = hdr_q;
		if (state_q == ST_FIXED) begin
			m_hdr.reserved = s_beat.data; // reserved byte closes a header without entries
		end else begin
			m_hdr.entry_count = hdr_q.entry_count + 8'd1;
		end
	end

	always_ff @(posedge enable) begin
		if (reset) begin
			state_q <= ST_IDLE;
			idx_q <= 3'd0;
			grp_q <= 2'd0;
			remain_q <= 16'd0;
			slot_hit_q <= 1'b0;
		end else if (xfer) begin
			case (state_q)
				ST_IDLE: begin
					if (s_beat.is_code && (s_beat.data == SYS_HEADER_CODE) && parse_enable) begin
						state_q <= ST_FIXED;
						idx_q <= 3'd0;
						hdr_q.entry_count <= 8'd0;
					end
				end
				ST_FIXED: begin
					idx_q <= idx_q + 3'd1;
					case (idx_q)
						3'd0: hdr_q.header_len[15:8] <= s_beat.data; // big endian
						3'd1: begin
							hdr_q.header_len[7:0] <= s_beat.data;
							remain_q <= len - FIXED_FIELD_BYTES;
						end
						3'd2: hdr_q.rate_bound[23:16] <= s_beat.data;
						3'd3: hdr_q.rate_bound[15:8] <= s_beat.data;
						3'd4: hdr_q.rate_bound[7:0] <= s_beat.data;
						3'd5: hdr_q.flags[15:8] <= s_beat.data;
						3'd6: hdr_q.flags[7:0] <= s_beat.data;
						default: begin
							hdr_q.reserved <= s_beat.data;
							grp_q <= 2'd0;
							state_q <= (remain_q == 16'd0) ? ST_IDLE : ST_ENTRY;
						end
					endcase
					if (bad_byte) begin
						state_q <= ST_IDLE;
					end
				end
				ST_ENTRY: begin
					remain_q <= remain_q - 16'd1;
					case (grp_q)
						2'd0: begin
							slot_hit_q <= id_audio || id_video; // b8, b9 and others dropped
							slot_q <= id_slot;
							grp_q <= 2'd1;
						end
						2'd1: begin
							b1_q <= s_beat.data;
							grp_q <= 2'd2;
						end
						default: begin
							grp_q <= 2'd0;
							hdr_q.entry_count <= hdr_q.entry_count + 8'd1;
							if (at_last) begin
								state_q <= ST_IDLE;
							end
						end
					endcase
					if (bad_byte) begin
						state_q <= ST_IDLE;
					end
				end
				default: state_q <= ST_IDLE;
			endcase
		end
	end

endmodule
